// File: all.f
+incdir+.
div_pkg.sv
fifo.sv
divide_module.sv
divide_top.sv
divide_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the divider testbench with Verilator.
# Exits non-zero when the build, the run or the regression fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f all.f --top-module divide_tb -o divide_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/divide_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    echo "see $LOG for details"
    exit 1
fi

if ! grep -q "Regression passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0

// File: divide_tb.sv
`default_nettype none

`include "div_settings.svh"

module divide_tb
    import div_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int ITEM_CYCLES  = `DIV_ED_WIDTH + 2;
    localparam int ITEM_BUDGET  = 300;
    localparam int WATCHDOG_TIME = ITEM_BUDGET * ITEM_CYCLES * 4 * CLK_PERIOD;
    localparam int STALL_LIMIT  = 4 * ITEM_CYCLES;   // blocked writes before reads resume
    localparam int SETTLE_CYCLES = 2 * ITEM_CYCLES;

    logic  clock;
    logic  reset;
    logic  in_wr_en;
    data_t in_dividend;
    data_t in_divisor;
    logic  in_full;
    logic  out_rd_en;
    data_t out_quotient;
    logic  out_empty;

    logic [31:0] lfsr_state;
    data_t       exp_queue[$];   // expected quotients, oldest first
    string       current_test;
    int          rd_mode;        // 0 hold off, 1 always read, 2 random
    logic        full_seen;
    int          total_written;
    int          total_read;
    int          checks;
    int          mismatches;
    int          other_errors;

    divide_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .in_wr_en     (in_wr_en),
        .in_dividend  (in_dividend),
        .in_divisor   (in_divisor),
        .in_full      (in_full),
        .out_rd_en    (out_rd_en),
        .out_quotient (out_quotient),
        .out_empty    (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;   // galois taps 32 22 2 1
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function logic [31:0] take_bits(input int n);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            result = {result[30:0], lfsr_state[0]};
        end
        return result;
    endfunction

    function automatic data_t apply_sign(input data_t mag, input logic negative);
        return negative ? -mag : mag;
    endfunction

    function data_t random_operand(input logic negative, input logic nonzero);
        logic [31:0] mag;
        mag = take_bits(20);
        if (nonzero && mag == '0) begin
            mag = 32'd1;
        end
        return apply_sign(data_t'(mag), negative);
    endfunction

    // magnitude division with round half up, sign applied last
    function automatic data_t model_quotient(input data_t a, input data_t b);
        logic [`DIV_D_WIDTH-1:0]  a_mag;
        logic [`DIV_D_WIDTH-1:0]  b_mag;
        logic [`DIV_ED_WIDTH-1:0] num;
        logic [`DIV_ED_WIDTH-1:0] q;
        logic [`DIV_D_WIDTH-1:0]  low;
        a_mag = a[`DIV_D_WIDTH-1] ? -a : a;
        b_mag = b[`DIV_D_WIDTH-1] ? -b : b;
        num = ({{(`DIV_ED_WIDTH - `DIV_D_WIDTH){1'b0}}, a_mag} << `DIV_Q_BITS)
            + {{(`DIV_ED_WIDTH - `DIV_D_WIDTH){1'b0}}, b_mag >> 1};
        q = num / {{(`DIV_ED_WIDTH - `DIV_D_WIDTH){1'b0}}, b_mag};
        low = q[`DIV_D_WIDTH-1:0];
        if (a[`DIV_D_WIDTH-1] ^ b[`DIV_D_WIDTH-1]) begin
            low = -low;
        end
        return data_t'(low);
    endfunction

    task automatic report_error(input string msg);
        $display("Error in %s: %s", current_test, msg);
        other_errors++;
    endtask

    task automatic check_result();
        data_t expected;
        checks++;
        if (exp_queue.size() == 0) begin
            report_error("a result came out with no pair outstanding");
        end else begin
            expected = exp_queue.pop_front();
            if (out_quotient !== expected) begin
                $display("Mismatch in %s: expected %0d, actual %0d",
                         current_test, expected, out_quotient);
                mismatches++;
            end
        end
        total_read++;
    endtask

    // one clock, inputs change on the falling edge
    task automatic step_cycle(input logic try_write, input data_t a, input data_t b,
                              output logic wrote);
        logic        rd;
        logic [31:0] bits;
        @(negedge clock);
        case (rd_mode)
            1: rd = 1'b1;
            2: begin
                bits = take_bits(1);
                rd = bits[0];
            end
            default: rd = 1'b0;
        endcase
        if (rd && !out_empty) begin
            check_result();   // popped at the next rising edge
        end
        out_rd_en = rd;
        wrote = 1'b0;
        in_wr_en = 1'b0;
        if (try_write && in_full) begin
            full_seen = 1'b1;
        end
        if (try_write && !in_full) begin
            in_dividend = a;
            in_divisor = b;
            in_wr_en = 1'b1;
            exp_queue.push_back(model_quotient(a, b));
            total_written++;
            wrote = 1'b1;
        end
    endtask

    task automatic send_pair(input data_t a, input data_t b, input logic throttled);
        logic        wrote;
        logic        try_write;
        logic [31:0] bits;
        int          stall;
        wrote = 1'b0;
        stall = 0;
        while (!wrote) begin
            try_write = 1'b1;
            if (throttled) begin
                bits = take_bits(1);
                try_write = bits[0];
            end
            step_cycle(try_write, a, b, wrote);
            if (try_write && !wrote) begin
                stall++;
            end
            if (stall > STALL_LIMIT && rd_mode == 0) begin
                rd_mode = 1;   // whole pipeline is full, start draining
            end
        end
    endtask

    // empty the expected queue, then look for anything left behind
    task automatic drain_results();
        logic wrote;
        while (exp_queue.size() > 0) begin
            step_cycle(1'b0, '0, '0, wrote);
        end
        rd_mode = 1;
        repeat (SETTLE_CYCLES) begin
            step_cycle(1'b0, '0, '0, wrote);
        end
        checks++;
        if (out_empty !== 1'b1) begin
            report_error("output FIFO not empty after all results were read");
        end
    endtask

    task automatic run_sign_test();
        logic [1:0] sel;
        current_test = "sign combinations";
        rd_mode = 1;
        for (int i = 0; i < 200; i++) begin
            sel = 2'(i);
            send_pair(random_operand(sel[0], 1'b0), random_operand(sel[1], 1'b1), 1'b0);
        end
        drain_results();
    endtask

    task automatic run_rounding_test();
        int         idx;
        logic [1:0] sel;
        current_test = "rounding edges";
        rd_mode = 1;
        idx = 0;
        // numerator lands exactly on k times the divisor
        for (int m = 1; m <= 4; m++) begin
            for (int k = 1; k <= 2; k++) begin
                sel = 2'(idx);
                send_pair(apply_sign(data_t'(m * (2 * k - 1)), sel[0]),
                          apply_sign(data_t'(2048 * m), sel[1]), 1'b0);
                idx++;
            end
        end
        // one below a multiple of 2047
        for (int t = 1; t <= 8; t++) begin
            sel = 2'(idx);
            send_pair(apply_sign(data_t'(2047 * t - 1), sel[0]),
                      apply_sign(data_t'(2047), sel[1]), 1'b0);
            idx++;
        end
        send_pair(data_t'(0), data_t'(1), 1'b0);
        send_pair(data_t'(0), data_t'(-3), 1'b0);
        send_pair(data_t'(0), data_t'(1000), 1'b0);
        send_pair(data_t'(0), data_t'(-65535), 1'b0);
        for (int i = 0; i < 4; i++) begin
            sel = 2'(i);
            send_pair(random_operand(sel[0], 1'b0), apply_sign(data_t'(1), sel[1]), 1'b0);
        end
        drain_results();
    endtask

    task automatic run_backpressure_test();
        int         start_reads;
        logic [1:0] sel;
        current_test = "output back-pressure";
        rd_mode = 0;
        full_seen = 1'b0;
        start_reads = total_read;
        for (int i = 0; i < 40; i++) begin
            sel = 2'(i);
            send_pair(random_operand(sel[0], 1'b0), random_operand(sel[1], 1'b1), 1'b0);
        end
        checks++;
        if (!full_seen) begin
            report_error("in_full never rose while the output was held off");
        end
        rd_mode = 1;
        drain_results();
        checks++;
        if (total_read - start_reads != 40) begin
            $display("Mismatch in %s: expected %0d, actual %0d",
                     current_test, 40, total_read - start_reads);
            mismatches++;
        end
    endtask

    task automatic run_throttle_test();
        logic [31:0] bits;
        current_test = "random throttling";
        rd_mode = 2;
        for (int i = 0; i < 60; i++) begin
            bits = take_bits(2);
            send_pair(random_operand(bits[0], 1'b0), random_operand(bits[1], 1'b1), 1'b1);
        end
        drain_results();
    endtask

    initial begin
        reset = 1'b1;
        in_wr_en = 1'b0;
        in_dividend = '0;
        in_divisor = '0;
        out_rd_en = 1'b0;
        lfsr_state = 32'd52;
        rd_mode = 0;
        full_seen = 1'b0;
        total_written = 0;
        total_read = 0;
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        current_test = "reset state";
        repeat (10) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        checks++;
        if (out_empty !== 1'b1) begin
            report_error("out_empty is not high after reset");
        end
        checks++;
        if (in_full !== 1'b0) begin
            report_error("in_full is not low after reset");
        end
        run_sign_test();
        run_rounding_test();
        run_backpressure_test();
        run_throttle_test();
        $display("checks %0d, written %0d, read %0d, mismatches %0d, other errors %0d",
                 checks, total_written, total_read, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout in %s: the run did not finish in %0d time units",
                 current_test, WATCHDOG_TIME);
        $display("checks %0d, written %0d, read %0d, mismatches %0d, other errors %0d",
                 checks, total_written, total_read, mismatches, other_errors);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: divide_top.sv
`default_nettype none

`include "div_settings.svh"

module divide_top
    import div_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  in_wr_en,
    input  data_t in_dividend,
    input  data_t in_divisor,
    output logic  in_full,
    input  logic  out_rd_en,
    output data_t out_quotient,
    output logic  out_empty
);

    pair_t head_pair;        // input FIFO head word
    logic  head_empty;
    logic  head_rd_en;
    data_t div_quotient;
    logic  div_wr_en;
    logic  res_full;

    // operand pairs waiting for the divider
    fifo #(
        .WIDTH ($bits(pair_t)),
        .DEPTH (`DIV_FIFO_DEPTH)
    ) u_in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   ({in_dividend, in_divisor}),
        .full  (in_full),
        .rd_en (head_rd_en),
        .dout  (head_pair),
        .empty (head_empty)
    );

    divide_module #(
        .Q_BITS  (`DIV_Q_BITS),
        .D_WIDTH (`DIV_D_WIDTH)
    ) u_divide (
        .clock     (clock),
        .reset     (reset),
        .dividend  (head_pair[2*`DIV_D_WIDTH-1:`DIV_D_WIDTH]),
        .divisor   (head_pair[`DIV_D_WIDTH-1:0]),
        .in_empty  (head_empty),
        .in_rd_en  (head_rd_en),
        .quotient  (div_quotient),
        .out_wr_en (div_wr_en),
        .out_full  (res_full)
    );

    // finished quotients
    fifo #(
        .WIDTH ($bits(data_t)),
        .DEPTH (`DIV_FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (div_wr_en),
        .din   (div_quotient),
        .full  (res_full),
        .rd_en (out_rd_en),
        .dout  (out_quotient),
        .empty (out_empty)
    );

endmodule

`default_nettype wire

// File: divide_module.sv
`default_nettype none

`include "div_settings.svh"

module divide_module
    import div_pkg::*;
#(
    parameter int Q_BITS  = `DIV_Q_BITS,
    parameter int D_WIDTH = `DIV_D_WIDTH
) (
    input  logic  clock,
    input  logic  reset,
    input  data_t dividend,
    input  data_t divisor,
    input  logic  in_empty,
    output logic  in_rd_en,
    output data_t quotient,
    output logic  out_wr_en,
    input  logic  out_full
);

    localparam int ED_WIDTH  = D_WIDTH + Q_BITS + 1;
    localparam int CNT_WIDTH = $clog2(ED_WIDTH + 1);

    typedef enum logic [1:0] {
        s_idle,
        s_iterate,
        s_write
    } state_t;

    state_t state;
    state_t next_state;

    logic [CNT_WIDTH-1:0] count;   // iteration index
    logic [2*ED_WIDTH:0]  aq;      // remainder on top, quotient below
    logic [2*ED_WIDTH:0]  aq_next;
    logic [2*ED_WIDTH:0]  aq_shift;
    logic [D_WIDTH-1:0]   b_mag;
    logic                 neg;     // exactly one operand negative

    logic [D_WIDTH-1:0]   dividend_mag;
    logic [D_WIDTH-1:0]   divisor_mag;
    logic [ED_WIDTH-1:0]  numerator;
    logic [ED_WIDTH:0]    b_ext;
    logic [ED_WIDTH:0]    rem_step;
    logic [ED_WIDTH:0]    rem_fix;
    logic                 last_step;
    logic [D_WIDTH-1:0]   q_mag;

    assign dividend_mag = dividend[D_WIDTH-1] ? -dividend : dividend;
    assign divisor_mag  = divisor[D_WIDTH-1] ? -divisor : divisor;

    // shifted dividend plus half divisor gives round to nearest
    assign numerator = (ED_WIDTH'(dividend_mag) << Q_BITS)
                     + ED_WIDTH'(divisor_mag >> 1);

    assign b_ext     = (ED_WIDTH + 1)'(b_mag);
    assign last_step = (count == CNT_WIDTH'(ED_WIDTH - 1));

    // one non-restoring step, sign of the old remainder picks add or subtract
    always_comb begin
        aq_shift = aq << 1;
        if (aq[2*ED_WIDTH]) begin
            rem_step = aq_shift[2*ED_WIDTH:ED_WIDTH] + b_ext;
        end else begin
            rem_step = aq_shift[2*ED_WIDTH:ED_WIDTH] - b_ext;
        end
        if (last_step && rem_step[ED_WIDTH]) begin
            rem_fix = rem_step + b_ext;   // restore a negative final remainder
        end else begin
            rem_fix = rem_step;
        end
        aq_next = {rem_fix, aq_shift[ED_WIDTH-1:1], ~rem_step[ED_WIDTH]};
    end

    assign in_rd_en  = (state == s_idle) && !in_empty;
    assign out_wr_en = (state == s_write) && !out_full;

    assign q_mag    = aq[D_WIDTH-1:0];   // low bits only, no saturation
    assign quotient = neg ? -q_mag : q_mag;

    always_comb begin
        next_state = state;
        case (state)
            s_idle: begin
                if (!in_empty) begin
                    next_state = s_iterate;
                end
            end
            s_iterate: begin
                if (last_step) begin
                    next_state = s_write;
                end
            end
            s_write: begin
                if (!out_full) begin
                    next_state = s_idle;
                end
            end
            default: begin
                next_state = s_idle;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= s_idle;
            count <= '0;
        end else begin
            state <= next_state;
            if (state == s_iterate) begin
                count <= count + CNT_WIDTH'(1);
            end else begin
                count <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            aq    <= {{(ED_WIDTH + 1){1'b0}}, numerator};
            b_mag <= divisor_mag;
            neg   <= dividend[D_WIDTH-1] ^ divisor[D_WIDTH-1];
        end else if (state == s_iterate) begin
            aq <= aq_next;
        end
    end

endmodule

`default_nettype wire

// File: fifo.sv
`default_nettype none

module fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 do_wr;
    logic                 do_rd;

    assign do_wr = wr_en && !full;   // drop writes into a full buffer
    assign do_rd = rd_en && !empty;

    assign full  = (count == CNT_WIDTH'(DEPTH));
    assign empty = (count == '0);

    // show-ahead, head word is always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + PTR_WIDTH'(1);   // wraps at depth
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + PTR_WIDTH'(1);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10: begin
                    count <= count + CNT_WIDTH'(1);
                end
                2'b01: begin
                    count <= count - CNT_WIDTH'(1);
                end
                default: begin
                    count <= count;   // idle, or read and write together
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: div_pkg.sv
`default_nettype none

`include "div_settings.svh"

package div_pkg;

    // signed operand or quotient
    typedef logic signed [`DIV_D_WIDTH-1:0] data_t;

    // input FIFO word, dividend in the upper half
    typedef logic [2*`DIV_D_WIDTH-1:0] pair_t;

endpackage

`default_nettype wire

// File: div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand and quotient width
`define DIV_D_WIDTH 32

// fractional bits kept in the quotient
`define DIV_Q_BITS 10

// expanded width of the shifted numerator
// one guard bit above data plus fraction, also the iteration count
`define DIV_ED_WIDTH (`DIV_D_WIDTH + `DIV_Q_BITS + 1)

// entries in each of the input and output FIFOs
// must be a power of two so the pointers wrap on their own
`define DIV_FIFO_DEPTH 16

`endif
